// ==== rtl/sum_cfg_pkg.sv ====
`default_nettype none

package sum_cfg_pkg;

  // frame geometry
  localparam int ROWS = 4;
  localparam int COLS = 16;
  localparam int WIN = 12;
  localparam int OUTS_PER_ROW = COLS - WIN + 1;

  // data widths
  localparam int SAMPLE_W = 8;
  localparam int SUM_W = 16;
  localparam int PAD_W = SUM_W - SAMPLE_W;
  localparam int CNT_W = 10;
  localparam int ROW_W = $clog2(ROWS);

  // start cycles before the first row
  localparam int WARMUP = 3;
  localparam int WARM_W = $clog2(WARMUP + 1);

  // memories
  localparam int SAMPLE_DEPTH = 64;
  localparam int RESULT_DEPTH = ROWS * OUTS_PER_ROW;
  localparam int SAMPLE_AW = $clog2(SAMPLE_DEPTH);
  localparam int RESULT_AW = $clog2(RESULT_DEPTH);

  // apb address map, one 32-bit word per entry
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;
  localparam logic [APB_AW-1:0] ADDR_CTRL = 12'h000;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h004;
  localparam logic [APB_AW-1:0] SAMPLE_BASE = 12'h100;
  localparam logic [APB_AW-1:0] SAMPLE_LIMIT = SAMPLE_BASE + APB_AW'(SAMPLE_DEPTH * 4);
  localparam logic [APB_AW-1:0] RESULT_BASE = 12'h200;
  localparam logic [APB_AW-1:0] RESULT_LIMIT = RESULT_BASE + APB_AW'(RESULT_DEPTH * 4);

  // register bits
  localparam int CTRL_GO_BIT = 0;
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

  // compare values for the counters
  localparam logic [CNT_W-1:0] WIN_LAST = CNT_W'(WIN - 1);
  localparam logic [CNT_W-1:0] COL_LAST = CNT_W'(COLS - 1);
  localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(ROWS - 1);
  localparam logic [WARM_W-1:0] WARM_DONE = WARM_W'(WARMUP);

endpackage

`default_nettype wire

// ==== rtl/sum_types_pkg.sv ====
`default_nettype none

package sum_types_pkg;

  // sequencer commands, one bit per datapath action
  typedef struct packed {
    logic count_en;
    logic ld_en;
    logic sum_en;
    logic cum_en;
    logic start_en;
    logic reset_en;
    logic out_valid;
    logic progress_done;
  } ctrl_cmd_t;

  // counter status back to the sequencer
  typedef struct packed {
    logic                          start_gt_warmup;
    logic [sum_cfg_pkg::CNT_W-1:0] col_count;
    logic                          row_eq_max;
  } cnt_status_t;

  // sample RAM write port, driven from the bus
  typedef struct packed {
    logic                              en;
    logic [sum_cfg_pkg::SAMPLE_AW-1:0] addr;
    logic [sum_cfg_pkg::SAMPLE_W-1:0]  data;
  } sample_wr_t;

  // result RAM write port, driven from the accumulator
  typedef struct packed {
    logic                              en;
    logic [sum_cfg_pkg::RESULT_AW-1:0] addr;
    logic [sum_cfg_pkg::SUM_W-1:0]     data;
  } result_wr_t;

  // software visible status
  typedef struct packed {
    logic busy;
    logic done;
  } status_t;

endpackage

`default_nettype wire

// ==== rtl/line_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_ram #(
  parameter type payload_t = logic [sum_cfg_pkg::SAMPLE_W-1:0],
  parameter int  DEPTH     = sum_cfg_pkg::SAMPLE_DEPTH
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                 rd_data
);

  payload_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/scan_counters.sv ====
`timescale 1ns/10ps
`default_nettype none

module scan_counters (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  sum_types_pkg::ctrl_cmd_t              cmd,
  output sum_types_pkg::cnt_status_t            cnt,
  output logic [sum_cfg_pkg::SAMPLE_AW-1:0]     rd_addr
);

  logic [sum_cfg_pkg::WARM_W-1:0] warm_q;
  logic [sum_cfg_pkg::CNT_W-1:0]  col_q;
  logic [sum_cfg_pkg::ROW_W-1:0]  row_q;
  logic                           col_wrap;
  logic [31:0]                    addr_full;

  // last column of a row is being issued
  assign col_wrap = cmd.count_en && (col_q == sum_cfg_pkg::COL_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      warm_q <= '0;
      col_q  <= '0;
      row_q  <= '0;
    end else if (cmd.reset_en) begin
      warm_q <= '0;
      col_q  <= '0;
      row_q  <= '0;
    end else begin
      // warm-up saturates until the frame ends
      if (cmd.start_en && (warm_q != sum_cfg_pkg::WARM_DONE)) begin
        warm_q <= warm_q + 1'b1;
      end
      if (cmd.ld_en || col_wrap) begin
        col_q <= '0;
      end else if (cmd.count_en) begin
        col_q <= col_q + 1'b1;
      end
      if (col_wrap) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  assign cnt.start_gt_warmup = (warm_q == sum_cfg_pkg::WARM_DONE);
  assign cnt.col_count       = col_q;
  assign cnt.row_eq_max      = (row_q == sum_cfg_pkg::ROW_LAST);

  // row major sample address
  assign addr_full = 32'(row_q) * 32'(sum_cfg_pkg::COLS) + 32'(col_q);
  assign rd_addr   = addr_full[sum_cfg_pkg::SAMPLE_AW-1:0];

  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    col_q <= sum_cfg_pkg::COL_LAST);

endmodule

`default_nettype wire

// ==== rtl/window_sum_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_sum_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      go,
  input  sum_types_pkg::cnt_status_t cnt,
  output sum_types_pkg::ctrl_cmd_t   cmd
);

  typedef enum logic [2:0] {
    S_IDLE   = 3'd0,
    S_START  = 3'd1,
    S_ROW    = 3'd2,
    S_SUM    = 3'd3,
    S_SLIDE  = 3'd4,
    S_FINISH = 3'd5
  } state_e;

  state_e state_q;
  state_e prev_q;
  state_e state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      prev_q  <= S_IDLE;
    end else begin
      state_q <= state_d;
      prev_q  <= state_q;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (go) state_d = S_START;
      S_START:  if (cnt.start_gt_warmup) state_d = S_ROW;
      S_ROW:    state_d = S_SUM;
      S_SUM:    if (cnt.col_count == sum_cfg_pkg::WIN_LAST) state_d = S_SLIDE;
      S_SLIDE: begin
        if (cnt.col_count == sum_cfg_pkg::COL_LAST) begin
          state_d = cnt.row_eq_max ? S_FINISH : S_ROW;
        end
      end
      S_FINISH: state_d = S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  always_comb begin
    cmd = '0;
    case (state_q)
      S_START: begin
        cmd.start_en = 1'b1;
      end
      S_ROW: begin
        cmd.ld_en    = 1'b1;
        cmd.count_en = 1'b1;
        // last window of the previous row completes here
        cmd.out_valid = (prev_q == S_SLIDE);
      end
      S_SUM: begin
        cmd.count_en = 1'b1;
        cmd.sum_en   = 1'b1;
      end
      S_SLIDE: begin
        cmd.count_en  = 1'b1;
        cmd.sum_en    = 1'b1;
        cmd.cum_en    = 1'b1;
        cmd.out_valid = 1'b1;
      end
      S_FINISH: begin
        cmd.progress_done = 1'b1;
        cmd.reset_en      = 1'b1;
        // last row has no following start of row, so its final window goes out here
        cmd.out_valid = (prev_q == S_SLIDE);
      end
      default: begin
        cmd = '0;
      end
    endcase
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state_q inside {S_IDLE, S_START, S_ROW, S_SUM, S_SLIDE, S_FINISH});

  a_load_vs_sum: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd.sum_en && cmd.ld_en));

endmodule

`default_nettype wire

// ==== rtl/window_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_accum (
  input  logic                              clk,
  input  logic                              rst_n,
  input  sum_types_pkg::ctrl_cmd_t          cmd,
  input  logic [sum_cfg_pkg::SAMPLE_W-1:0]  rd_data,
  output sum_types_pkg::result_wr_t         res_wr
);

  logic ld_d;
  logic sum_d;
  logic cum_d;
  logic out_d;
  logic rst_d;

  logic [sum_cfg_pkg::SAMPLE_W-1:0]  win_q [sum_cfg_pkg::WIN];
  logic [sum_cfg_pkg::SUM_W-1:0]     sum_q;
  logic [sum_cfg_pkg::SUM_W-1:0]     sum_in;
  logic [sum_cfg_pkg::SUM_W-1:0]     sum_out;
  logic [sum_cfg_pkg::RESULT_AW-1:0] res_addr_q;

  // commands lined up with the sample RAM read data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_d  <= 1'b0;
      sum_d <= 1'b0;
      cum_d <= 1'b0;
      out_d <= 1'b0;
      rst_d <= 1'b0;
    end else begin
      ld_d  <= cmd.ld_en;
      sum_d <= cmd.sum_en;
      cum_d <= cmd.cum_en;
      out_d <= cmd.out_valid;
      rst_d <= cmd.reset_en;
    end
  end

  assign sum_in  = {{sum_cfg_pkg::PAD_W{1'b0}}, rd_data};
  // oldest sample leaves once the window is full
  assign sum_out = cum_d ? {{sum_cfg_pkg::PAD_W{1'b0}}, win_q[sum_cfg_pkg::WIN-1]} : '0;

  always_ff @(posedge clk) begin
    if (ld_d) begin
      sum_q <= '0;
      for (int i = 0; i < sum_cfg_pkg::WIN; i++) begin
        win_q[i] <= '0;
      end
    end else if (sum_d) begin
      sum_q    <= sum_q + sum_in - sum_out;
      win_q[0] <= rd_data;
      for (int i = 1; i < sum_cfg_pkg::WIN; i++) begin
        win_q[i] <= win_q[i-1];
      end
    end
  end

  // result slot, one per finished window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_addr_q <= '0;
    end else if (rst_d) begin
      res_addr_q <= '0;
    end else if (out_d) begin
      res_addr_q <= res_addr_q + 1'b1;
    end
  end

  assign res_wr.en   = out_d;
  assign res_wr.addr = res_addr_q;
  assign res_wr.data = sum_q;

  a_res_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    res_addr_q < sum_cfg_pkg::RESULT_DEPTH);

endmodule

`default_nettype wire

// ==== rtl/apb_sum_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_sum_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [sum_cfg_pkg::APB_AW-1:0]    paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [sum_cfg_pkg::APB_DW-1:0]    pwdata,
  output logic [sum_cfg_pkg::APB_DW-1:0]    prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              irq,
  output logic                              go,
  output sum_types_pkg::sample_wr_t         smp_wr,
  output logic [sum_cfg_pkg::RESULT_AW-1:0] res_rd_addr,
  input  logic [sum_cfg_pkg::SUM_W-1:0]     res_rd_data,
  input  sum_types_pkg::ctrl_cmd_t          cmd
);

  sum_types_pkg::status_t status_q;
  logic                   res_valid_q;
  logic                   access;
  logic                   wr_acc;
  logic                   rd_acc;
  logic                   ctrl_hit;
  logic                   status_hit;
  logic                   smp_hit;
  logic                   res_hit;
  logic                   unmapped;
  logic [sum_cfg_pkg::APB_AW-1:0] smp_off;
  logic [sum_cfg_pkg::APB_AW-1:0] res_off;

  assign access = psel && penable;
  assign wr_acc = access && pwrite;
  assign rd_acc = access && !pwrite;

  // address decode, word aligned windows
  assign ctrl_hit   = (paddr == sum_cfg_pkg::ADDR_CTRL);
  assign status_hit = (paddr == sum_cfg_pkg::ADDR_STATUS);
  assign smp_hit    = (paddr >= sum_cfg_pkg::SAMPLE_BASE) && (paddr < sum_cfg_pkg::SAMPLE_LIMIT)
                      && (paddr[1:0] == 2'b00);
  assign res_hit    = (paddr >= sum_cfg_pkg::RESULT_BASE) && (paddr < sum_cfg_pkg::RESULT_LIMIT)
                      && (paddr[1:0] == 2'b00);
  assign unmapped   = !(ctrl_hit || status_hit || smp_hit || res_hit);

  assign smp_off = paddr - sum_cfg_pkg::SAMPLE_BASE;
  assign res_off = paddr - sum_cfg_pkg::RESULT_BASE;

  // memories belong to the engine while busy
  assign pslverr = access && (unmapped ||
                   (status_q.busy && ((smp_hit && pwrite) || (res_hit && !pwrite))));
  assign pready  = 1'b1;

  assign go = wr_acc && ctrl_hit && pwdata[sum_cfg_pkg::CTRL_GO_BIT] && !status_q.busy;

  assign smp_wr.en   = wr_acc && smp_hit && !status_q.busy;
  assign smp_wr.addr = smp_off[sum_cfg_pkg::SAMPLE_AW+1:2];
  assign smp_wr.data = pwdata[sum_cfg_pkg::SAMPLE_W-1:0];

  // result read starts in the setup phase
  assign res_rd_addr = res_off[sum_cfg_pkg::RESULT_AW+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      status_q    <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (go) begin
        status_q.busy <= 1'b1;
        status_q.done <= 1'b0;
      end else if (cmd.progress_done) begin
        status_q.busy <= 1'b0;
        status_q.done <= 1'b1;
      end else if (wr_acc && status_hit && pwdata[sum_cfg_pkg::STAT_DONE_BIT]) begin
        status_q.done <= 1'b0;
      end
      // result RAM holds nothing meaningful before the first frame
      if (cmd.progress_done) begin
        res_valid_q <= 1'b1;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_acc && status_hit) begin
      prdata[sum_cfg_pkg::STAT_BUSY_BIT] = status_q.busy;
      prdata[sum_cfg_pkg::STAT_DONE_BIT] = status_q.done;
    end else if (rd_acc && res_hit && !status_q.busy && res_valid_q) begin
      prdata[sum_cfg_pkg::SUM_W-1:0] = res_rd_data;
    end
  end

  assign irq = status_q.done;

  a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== rtl/window_sum_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_sum_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [sum_cfg_pkg::APB_AW-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [sum_cfg_pkg::APB_DW-1:0] pwdata,
  output logic [sum_cfg_pkg::APB_DW-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           irq
);

  logic                              go;
  sum_types_pkg::ctrl_cmd_t          cmd;
  sum_types_pkg::cnt_status_t        cnt;
  sum_types_pkg::sample_wr_t         smp_wr;
  sum_types_pkg::result_wr_t         res_wr;
  logic [sum_cfg_pkg::SAMPLE_AW-1:0] smp_rd_addr;
  logic [sum_cfg_pkg::SAMPLE_W-1:0]  smp_rd_data;
  logic [sum_cfg_pkg::RESULT_AW-1:0] res_rd_addr;
  logic [sum_cfg_pkg::SUM_W-1:0]     res_rd_data;

  apb_sum_regs u_regs (
    .clk, .rst_n,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .irq, .go, .smp_wr, .res_rd_addr, .res_rd_data, .cmd
  );

  window_sum_ctrl u_ctrl (.clk, .rst_n, .go, .cnt, .cmd);

  scan_counters u_counters (.clk, .rst_n, .cmd, .cnt, .rd_addr(smp_rd_addr));

  window_accum u_accum (.clk, .rst_n, .cmd, .rd_data(smp_rd_data), .res_wr);

  // frame samples, written from the bus and scanned by the engine
  line_ram #(
    .payload_t (logic [sum_cfg_pkg::SAMPLE_W-1:0]),
    .DEPTH     (sum_cfg_pkg::SAMPLE_DEPTH)
  ) u_sample_ram (
    .clk,
    .wr_en   (smp_wr.en),
    .wr_addr (smp_wr.addr),
    .wr_data (smp_wr.data),
    .rd_addr (smp_rd_addr),
    .rd_data (smp_rd_data)
  );

  // window sums, written by the engine and read from the bus
  line_ram #(
    .payload_t (logic [sum_cfg_pkg::SUM_W-1:0]),
    .DEPTH     (sum_cfg_pkg::RESULT_DEPTH)
  ) u_result_ram (
    .clk,
    .wr_en   (res_wr.en),
    .wr_addr (res_wr.addr),
    .wr_data (res_wr.data),
    .rd_addr (res_rd_addr),
    .rd_data (res_rd_data)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_apb_tasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// byte address of a sample word
function automatic logic [11:0] sample_addr(input int idx);
  return sum_cfg_pkg::SAMPLE_BASE + 12'(4 * idx);
endfunction

// byte address of a result word
function automatic logic [11:0] result_addr(input int idx);
  return sum_cfg_pkg::RESULT_BASE + 12'(4 * idx);
endfunction

// one window of WIN samples starting at column pos of a row
function automatic logic [15:0] window_sum_of(input int row, input int pos);
  int total;
  total = 0;
  for (int k = 0; k < sum_cfg_pkg::WIN; k++) begin
    total += int'(frame[row * sum_cfg_pkg::COLS + pos + k]);
  end
  return 16'(total);
endfunction

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
  @(posedge clk);
  paddr   <= addr;
  pwrite  <= 1'b1;
  pwdata  <= data;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge clk);
  penable <= 1'b1;
  // no wait states, so the transfer completes in this access phase
  @(negedge clk);
  check_value("pready", 32'h1, 32'(pready));
  err = pslverr;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
  pwrite  <= 1'b0;
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
  @(posedge clk);
  paddr   <= addr;
  pwrite  <= 1'b0;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge clk);
  penable <= 1'b1;
  // result RAM data arrives in the access phase
  @(negedge clk);
  check_value("pready", 32'h1, 32'(pready));
  data = prdata;
  err  = pslverr;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

`endif

// ==== testbench/tb_window_sum.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_window_sum;

  localparam int CLK_PERIOD = 20;
  localparam int FRAME_SIZE = sum_cfg_pkg::ROWS * sum_cfg_pkg::COLS;
  localparam int NUM_SUMS   = sum_cfg_pkg::RESULT_DEPTH;
  localparam int STIM_WORDS = FRAME_SIZE + NUM_SUMS;
  localparam int FRAME_CYCLES = sum_cfg_pkg::ROWS * (sum_cfg_pkg::COLS + 4) + sum_cfg_pkg::WARMUP;
  // one frame plus the bus traffic around it
  localparam int RUN_CYCLES = FRAME_CYCLES + 200;
  localparam longint WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD * 2;
  localparam int IRQ_WAIT_CYCLES = 2 * FRAME_CYCLES;
  localparam logic [31:0] RAND_SEED = 32'h7036_42cc;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        irq;

  logic [15:0] stim_mem [STIM_WORDS];
  logic [7:0]  frame [FRAME_SIZE];
  logic [15:0] expected [NUM_SUMS];

  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  int errors_at_start;
  string test_name;

  window_sum_top UUT (
    .clk, .rst_n,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .irq
  );

  `include "tb_apb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, test_name,
               errors - errors_at_start);
    end
  endtask

  task automatic wait_for_irq();
    int  cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < IRQ_WAIT_CYCLES) begin
      @(negedge clk);
      if (irq) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("irq did not rise within %0d cycles of waiting for the frame end",
               IRQ_WAIT_CYCLES);
    end
  endtask

  task automatic load_frame();
    logic err;
    for (int i = 0; i < FRAME_SIZE; i++) begin
      apb_write(sample_addr(i), {24'h0, frame[i]}, err);
      check_value($sformatf("pslverr sample %0d", i), 32'h0, 32'(err));
    end
  endtask

  task automatic start_frame();
    logic err;
    apb_write(sum_cfg_pkg::ADDR_CTRL, 32'h1, err);
    check_value("pslverr go", 32'h0, 32'(err));
  endtask

  // waits for the end of the frame and reads STATUS and every result
  task automatic check_frame_results();
    logic [31:0] data;
    logic        err;
    wait_for_irq();
    apb_read(sum_cfg_pkg::ADDR_STATUS, data, err);
    check_value("STATUS", 32'h2, data);
    for (int i = 0; i < NUM_SUMS; i++) begin
      apb_read(result_addr(i), data, err);
      check_value($sformatf("prdata result %0d", i), {16'h0, expected[i]}, data);
      check_value($sformatf("pslverr result %0d", i), 32'h0, 32'(err));
    end
  endtask

  task automatic check_reset_state();
    logic [31:0] data;
    logic        err;
    start_test("reset state");
    @(negedge clk);
    check_value("irq", 32'h0, 32'(irq));
    apb_read(sum_cfg_pkg::ADDR_STATUS, data, err);
    check_value("STATUS", 32'h0, data);
    for (int i = 0; i < NUM_SUMS; i++) begin
      apb_read(result_addr(i), data, err);
      check_value($sformatf("prdata result %0d", i), 32'h0, data);
    end
    finish_test();
  endtask

  task automatic run_directed_frame();
    logic [31:0] data;
    logic        err;
    for (int i = 0; i < FRAME_SIZE; i++) begin
      frame[i] = stim_mem[i][7:0];
    end
    for (int i = 0; i < NUM_SUMS; i++) begin
      expected[i] = stim_mem[FRAME_SIZE + i];
    end
    start_test("load and start directed frame");
    load_frame();
    start_frame();
    finish_test();

    start_test("access rules while busy");
    apb_read(sum_cfg_pkg::ADDR_STATUS, data, err);
    check_value("STATUS", 32'h1, data);
    apb_write(sample_addr(0), 32'h5a, err);
    check_value("pslverr sample write", 32'h1, 32'(err));
    apb_read(result_addr(0), data, err);
    check_value("pslverr result read", 32'h1, 32'(err));
    apb_write(12'h080, 32'h0, err);
    check_value("pslverr unmapped", 32'h1, 32'(err));
    // a second go is dropped quietly
    apb_write(sum_cfg_pkg::ADDR_CTRL, 32'h1, err);
    check_value("pslverr second go", 32'h0, 32'(err));
    finish_test();

    start_test("directed frame results");
    check_frame_results();
    finish_test();
  endtask

  task automatic check_done_clear();
    logic [31:0] data;
    logic        err;
    start_test("done clear");
    apb_write(sum_cfg_pkg::ADDR_STATUS, 32'h2, err);
    check_value("pslverr", 32'h0, 32'(err));
    @(negedge clk);
    check_value("irq", 32'h0, 32'(irq));
    apb_read(sum_cfg_pkg::ADDR_STATUS, data, err);
    check_value("STATUS", 32'h0, data);
    finish_test();
  endtask

  task automatic run_random_frame();
    logic [31:0] data;
    logic        err;
    start_test("random frame");
    for (int i = 0; i < FRAME_SIZE; i++) begin
      frame[i] = 8'($urandom());
    end
    // saturated last row
    for (int c = 0; c < sum_cfg_pkg::COLS; c++) begin
      frame[(sum_cfg_pkg::ROWS - 1) * sum_cfg_pkg::COLS + c] = 8'hFF;
    end
    for (int r = 0; r < sum_cfg_pkg::ROWS; r++) begin
      for (int j = 0; j < sum_cfg_pkg::OUTS_PER_ROW; j++) begin
        expected[r * sum_cfg_pkg::OUTS_PER_ROW + j] = window_sum_of(r, j);
      end
    end
    load_frame();
    start_frame();
    check_frame_results();
    // every window of the saturated row holds 12 x 0xff
    for (int j = 0; j < sum_cfg_pkg::OUTS_PER_ROW; j++) begin
      apb_read(result_addr((sum_cfg_pkg::ROWS - 1) * sum_cfg_pkg::OUTS_PER_ROW + j), data, err);
      check_value($sformatf("prdata saturated result %0d", j), 32'h0BF4, data);
    end
    finish_test();
  endtask

  initial begin
    rst_n           = 1'b0;
    paddr           = '0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    pwdata          = '0;
    checks          = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    void'($urandom(RAND_SEED));
    $readmemh("testbench/window_sum_stimulus.txt", stim_mem);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    check_reset_state();
    run_directed_frame();
    check_done_clear();
    run_random_frame();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/window_sum_stimulus.txt ====
// words 0x00-0x3f: frame samples in hex, one row of 16 columns per line
// words 0x40-0x53: expected 16-bit window sums, one row of 5 positions per line
// row 0 rising ramp
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
// row 1 flat
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
// row 2 falling ramp
f0 e0 d0 c0 b0 a0 90 80 70 60 50 40 30 20 10 00
// row 3 alternating
ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00
@40
004e 005a 0066 0072 007e
00c0 00c0 00c0 00c0 00c0
0720 0660 05a0 04e0 0420
05fa 05fa 05fa 05fa 05fa

// ==== sim.f ====
+incdir+testbench
rtl/sum_cfg_pkg.sv
rtl/sum_types_pkg.sv
rtl/line_ram.sv
rtl/scan_counters.sv
rtl/window_sum_ctrl.sv
rtl/window_accum.sv
rtl/apb_sum_regs.sv
rtl/window_sum_top.sv
testbench/tb_window_sum.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the window sum testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_window_sum -f sim.f -o tb_window_sum

./obj_dir/tb_window_sum 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "run ended without a result, see sim.log"
  exit 1
fi
exit 0
